//--- build.f
verilog/ahb_pkg.sv
verilog/soc_map_pkg.sv
verilog/ahb_decoder.sv
verilog/ahb_ram.sv
verilog/gpio_port.sv
verilog/int_gen.sv
verilog/soc_top.sv
tb/soc_top_properties.sv
tb/tb_soc_top.sv

//--- Bender.yml
package:
  name: soc_top

sources:
  - verilog/ahb_pkg.sv
  - verilog/soc_map_pkg.sv
  - verilog/ahb_decoder.sv
  - verilog/ahb_ram.sv
  - verilog/gpio_port.sv
  - verilog/int_gen.sv
  - verilog/soc_top.sv
  - target: test
    files:
      - tb/soc_top_properties.sv
      - tb/tb_soc_top.sv

//--- tb/tb_soc_top.sv
module tb_soc_top;
    import ahb_pkg::*;
    import soc_map_pkg::*;

    localparam int PORTS        = 2;
    localparam int RESET_CYCLES = 16;

    // One table row, one AHB-Lite transfer
    typedef struct packed
    {
        logic             wr;
        hsize_t           size;
        logic [31:0]      addr;
        logic [31:0]      wdata;
        logic [31:0]      pins;       // gpio_i[0], port 1 gets the inverse
        logic [5:0]       dev;        // dev_irq
        logic [3:0]       gap;        // Idle cycles after new pins, 0 = back to back
        logic [31:0]      exp_rdata;
        logic             exp_err;
        logic [1:0][31:0] exp_o;      // Seen in this data phase
        logic [1:0][31:0] exp_oe;
        logic [31:0]      exp_irq;
        logic             exp_ext;
    } entry_t;

    logic                CLK = 1'b0;
    logic                RES_ORG;
    ahb_req_t            bus_req;
    ahb_rsp_t            bus_rsp;
    gpio_word_t          gpio_i  [PORTS];
    gpio_word_t          gpio_o  [PORTS];
    gpio_word_t          gpio_oe [PORTS];
    logic [DEV_IRQS-1:0] dev_irq;
    irq_vec_t            irq;
    logic                irq_ext;

    entry_t              tbl [$];
    integer              seed = 32'h54240113;
    int                  cycle_cnt = 0;

    // Reference state while the table is built
    logic [31:0]         ram_m [256];
    logic [1:0][31:0]    o_m;
    logic [1:0][31:0]    oe_m;
    logic [31:0]         gen_m;
    logic [31:0]         pins_m;
    logic [5:0]          dev_m;
    logic                ext_m;
    logic [3:0]          gap_next;

    soc_top #(.GPIO_PORTS(PORTS), .RAM_WORDS(256)) DUT
    (
        .CLK     (CLK),
        .RES_ORG (RES_ORG),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o),
        .gpio_oe (gpio_oe),
        .dev_irq (dev_irq),
        .irq     (irq),
        .irq_ext (irq_ext)
    );

    always #20 CLK = ~CLK;  // Period 40

    // --------------------------------------------------
    // Failure reporting
    // --------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] got);
        fail_run($sformatf("Error: %s expected %h, got %h", sig, exp, got));
    endtask

    // Watchdog
    always @(posedge CLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > tbl.size() * 8 + RESET_CYCLES + 100)
            fail_run("Timeout: the transfer table did not finish within the cycle limit");
    end

    // --------------------------------------------------
    // Table construction with expected values
    // --------------------------------------------------
    task automatic set_inputs(input logic [31:0] pins, input logic [5:0] dev);
        pins_m   = pins;
        dev_m    = dev;
        gap_next = 4'd3;  // Room for the two sync flops
    endtask

    task automatic add_xfer(input logic wr, input hsize_t size, input logic [31:0] addr,
                            input logic [31:0] wdata);
        entry_t     e;
        logic [3:0] be;
        logic [3:0] port;
        e         = '0;
        e.wr      = wr;
        e.size    = size;
        e.addr    = addr;
        e.wdata   = wdata;
        e.pins    = pins_m;
        e.dev     = dev_m;
        e.gap     = gap_next;
        e.exp_o   = o_m;
        e.exp_oe  = oe_m;
        e.exp_irq = gen_m | {26'b0, dev_m};  // Device lines on bits 5:0
        e.exp_ext = ext_m;
        gap_next  = '0;
        port      = addr[7:4];
        case (size)
            BYTE:    be = 4'b0001 << addr[1:0];
            HALF:    be = addr[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;
        endcase
        if ((addr & 32'hFFFF_FC00) == 32'h2000_0000)
        begin
            e.exp_rdata = ram_m[addr[9:2]];
            if (wr)
                for (int b = 0; b < 4; b++)
                    if (be[b])
                        ram_m[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
        end
        else if ((addr & 32'hFFFF_FF00) == 32'h4000_0000)
        begin
            if (port < PORTS)  // Missing ports read zero
            begin
                case (addr[3:0])
                    4'h0:    e.exp_rdata = o_m[port];
                    4'h4:    e.exp_rdata = oe_m[port];
                    4'h8:    e.exp_rdata = port[0] ? ~pins_m : pins_m;
                    default: e.exp_rdata = '0;
                endcase
                if (wr && addr[3:0] == 4'h0)
                    o_m[port] = wdata;
                if (wr && addr[3:0] == 4'h4)
                    oe_m[port] = wdata;
            end
        end
        else if ((addr & 32'hFFFF_FF00) == 32'h4000_1000)
        begin
            case (addr[7:0])
                8'h00:   e.exp_rdata = gen_m;
                8'h04:   e.exp_rdata = {31'b0, ext_m};
                8'h08:   e.exp_rdata = e.exp_irq;
                default: e.exp_rdata = '0;
            endcase
            if (wr && addr[7:0] == 8'h00)
                gen_m = wdata;
            if (wr && addr[7:0] == 8'h04)
                ext_m = wdata[0];
        end
        else
            e.exp_err = 1'b1;  // Unmapped
        tbl.push_back(e);
    endtask

    task automatic build_table();
        o_m      = '0;
        oe_m     = '0;
        gen_m    = '0;
        pins_m   = '0;
        dev_m    = '0;
        ext_m    = 1'b0;
        gap_next = '0;
        // RAM words back to back
        for (int k = 0; k < 6; k++)
            add_xfer(1'b1, WORD, 32'h2000_0000 + 4*k, $random(seed));
        for (int k = 0; k < 6; k++)
            add_xfer(1'b0, WORD, 32'h2000_0000 + 4*k, 0);
        add_xfer(1'b1, WORD, 32'h2000_03FC, $random(seed));  // Top of window
        add_xfer(1'b0, WORD, 32'h2000_03FC, 0);
        // Byte and halfword lanes
        add_xfer(1'b1, WORD, 32'h2000_0100, 32'h1122_3344);
        add_xfer(1'b1, WORD, 32'h2000_0104, 32'h6677_8899);
        add_xfer(1'b1, BYTE, 32'h2000_0102, 32'h00AA_0000);
        add_xfer(1'b1, HALF, 32'h2000_0100, 32'h0000_BEEF);
        add_xfer(1'b1, BYTE, 32'h2000_0107, 32'h5500_0000);
        add_xfer(1'b0, WORD, 32'h2000_0100, 0);
        add_xfer(1'b0, WORD, 32'h2000_0104, 0);
        // GPIO
        set_inputs(32'hA5A5_0F0F, 6'b0);
        add_xfer(1'b1, WORD, 32'h4000_0000, 32'hDEAD_0001);  // Port 0 O
        add_xfer(1'b1, WORD, 32'h4000_0014, 32'h0000_FFFF);  // Port 1 OE
        add_xfer(1'b0, WORD, 32'h4000_0000, 0);
        add_xfer(1'b0, WORD, 32'h4000_0014, 0);
        add_xfer(1'b0, WORD, 32'h4000_0008, 0);
        add_xfer(1'b0, WORD, 32'h4000_0018, 0);
        add_xfer(1'b1, WORD, 32'h4000_0008, 32'hFFFF_FFFF);  // Read-only offset
        add_xfer(1'b1, WORD, 32'h4000_0030, 32'h1234_5678);  // No port 3
        add_xfer(1'b0, WORD, 32'h4000_0030, 0);
        add_xfer(1'b0, WORD, 32'h4000_0008, 0);
        // Interrupts, new pins too
        set_inputs(32'h5A5A_F0F0, 6'b10_0101);
        add_xfer(1'b0, WORD, 32'h4000_0008, 0);
        add_xfer(1'b1, WORD, 32'h4000_1000, 32'h8000_0F07);  // Bits 0 and 2 overlap dev
        add_xfer(1'b0, WORD, 32'h4000_1008, 0);
        add_xfer(1'b0, WORD, 32'h4000_1000, 0);
        add_xfer(1'b1, WORD, 32'h4000_1004, 32'h0000_0001);
        add_xfer(1'b0, WORD, 32'h4000_1004, 0);
        // Unmapped, RAM stays intact
        add_xfer(1'b1, WORD, 32'h3000_0000, 32'hFFFF_FFFF);
        add_xfer(1'b0, WORD, 32'h2000_0000, 0);
        add_xfer(1'b0, WORD, 32'h3000_0000, 0);
        add_xfer(1'b0, WORD, 32'h2000_0100, 0);
    endtask

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic check_reset_state();
        for (int p = 0; p < PORTS; p++)
        begin
            assert (gpio_o[p] === '0)
                else report_mismatch($sformatf("gpio_o[%0d]", p), '0, gpio_o[p]);
            assert (gpio_oe[p] === '0)
                else report_mismatch($sformatf("gpio_oe[%0d]", p), '0, gpio_oe[p]);
        end
        assert (irq === '0) else report_mismatch("irq", '0, irq);
        assert (irq_ext === 1'b0) else report_mismatch("irq_ext", '0, irq_ext);
        assert (bus_rsp.hreadyout === 1'b1)
            else report_mismatch("bus_rsp.hreadyout", 1'b1, bus_rsp.hreadyout);
        assert (bus_rsp.hresp === OKAY)
            else report_mismatch("bus_rsp.hresp", OKAY, bus_rsp.hresp);
    endtask

    task automatic check_response(input entry_t e, inout int err_cyc);
        if (e.exp_err)
        begin
            // Low then high hreadyout, ERROR in both
            assert (bus_rsp.hresp === ERROR)
                else report_mismatch("bus_rsp.hresp", ERROR, bus_rsp.hresp);
            assert (bus_rsp.hreadyout === (err_cyc != 0))
                else report_mismatch("bus_rsp.hreadyout", err_cyc != 0, bus_rsp.hreadyout);
            err_cyc = (err_cyc == 0) ? 1 : 0;
        end
        else
        begin
            assert (bus_rsp.hreadyout === 1'b1)
                else report_mismatch("bus_rsp.hreadyout", 1'b1, bus_rsp.hreadyout);
            assert (bus_rsp.hresp === OKAY)
                else report_mismatch("bus_rsp.hresp", OKAY, bus_rsp.hresp);
            if (!e.wr)
                assert (bus_rsp.hrdata === e.exp_rdata)
                    else report_mismatch("bus_rsp.hrdata", e.exp_rdata, bus_rsp.hrdata);
            for (int p = 0; p < PORTS; p++)
            begin
                assert (gpio_o[p] === e.exp_o[p])
                    else report_mismatch($sformatf("gpio_o[%0d]", p), e.exp_o[p], gpio_o[p]);
                assert (gpio_oe[p] === e.exp_oe[p])
                    else report_mismatch($sformatf("gpio_oe[%0d]", p), e.exp_oe[p],
                                         gpio_oe[p]);
            end
            assert (irq === e.exp_irq) else report_mismatch("irq", e.exp_irq, irq);
            assert (irq_ext === e.exp_ext) else report_mismatch("irq_ext", e.exp_ext, irq_ext);
        end
    endtask

    // --------------------------------------------------
    // AHB driver, address and data phases overlap
    // --------------------------------------------------
    task automatic run_table();
        int       ap;       // Row in address phase
        int       dp;       // Row in data phase
        int       idx;      // Next row to issue
        int       prep;     // Row whose pins are applied
        int       idle;
        int       err_cyc;
        logic     rdy;
        ahb_req_t nxt;
        ap      = -1;
        dp      = -1;
        idx     = 0;
        prep    = -1;
        idle    = 0;
        err_cyc = 0;
        rdy     = 1'b1;
        while (idx < tbl.size() || ap >= 0 || dp >= 0)
        begin
            @(posedge CLK);
            if (rdy)  // Otherwise hold the bus
            begin
                dp = ap;
                ap = -1;
                if (idle > 0)
                    idle--;
                else if (idx < tbl.size())
                begin
                    if (tbl[idx].gap == 0 || prep == idx)
                    begin
                        ap = idx;
                        idx++;
                    end
                    else if (dp < 0)
                    begin
                        // Pipeline empty, new pins and device lines
                        gpio_i[0] <= tbl[idx].pins;
                        gpio_i[1] <= ~tbl[idx].pins;
                        dev_irq   <= tbl[idx].dev;
                        idle = tbl[idx].gap;
                        prep = idx;
                    end
                end
                nxt = '0;
                if (ap >= 0)
                begin
                    nxt.htrans = NONSEQ;
                    nxt.hwrite = tbl[ap].wr;
                    nxt.hsize  = tbl[ap].size;
                    nxt.haddr  = tbl[ap].addr;
                end
                if (dp >= 0 && tbl[dp].wr)
                    nxt.hwdata = tbl[dp].wdata;  // Data phase
                bus_req <= nxt;
            end
            @(negedge CLK);
            rdy = bus_rsp.hreadyout;
            if (dp >= 0)
                check_response(tbl[dp], err_cyc);
        end
    endtask

    initial
    begin
        RES_ORG = 1'b1;
        bus_req = '0;
        dev_irq = '0;
        for (int p = 0; p < PORTS; p++)
            gpio_i[p] = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge CLK);
        RES_ORG <= 1'b0;
        @(negedge CLK);
        check_reset_state();
        run_table();
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- tb/soc_top_properties.sv
module soc_top_properties
(
    input logic              CLK,
    input logic              RES_ORG,
    input ahb_pkg::ahb_req_t bus_req,
    input ahb_pkg::ahb_rsp_t bus_rsp,
    input logic              irq_ext
);
    import ahb_pkg::*;

    logic wr_seen;  // Write accepted since reset

    always_ff @(posedge CLK or posedge RES_ORG)
    begin
        if (RES_ORG)
            wr_seen <= 1'b0;
        else if (bus_req.hwrite && bus_rsp.hreadyout
                 && (bus_req.htrans == NONSEQ || bus_req.htrans == SEQ))
            wr_seen <= 1'b1;
    end

    // Default slave, low ERROR cycle then high ERROR cycle
    err_two_cycle: assert property (@(posedge CLK) disable iff (RES_ORG)
        (bus_rsp.hresp == ERROR && !bus_rsp.hreadyout)
        |=> (bus_rsp.hresp == ERROR && bus_rsp.hreadyout))
        else $error("ERROR response did not complete in its second cycle");

    ext_quiet: assert property (@(posedge CLK) disable iff (RES_ORG)
        !wr_seen |-> !irq_ext)
        else $error("irq_ext set without any bus write");

    // At most one wait state
    one_wait: assert property (@(posedge CLK) disable iff (RES_ORG)
        !bus_rsp.hreadyout |=> bus_rsp.hreadyout)
        else $error("hreadyout low for two cycles in a row");

endmodule

bind soc_top soc_top_properties u_props
(
    .CLK     (CLK),
    .RES_ORG (RES_ORG),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .irq_ext (irq_ext)
);

//--- verilog/soc_top.sv
module soc_top
#(
    parameter int GPIO_PORTS = 2,    // 1 to 8
    parameter int RAM_WORDS  = 256   // 64 to 256
)
(
    input  logic                             CLK,
    input  logic                             RES_ORG,
    input  ahb_pkg::ahb_req_t                bus_req,
    output ahb_pkg::ahb_rsp_t                bus_rsp,
    input  soc_map_pkg::gpio_word_t          gpio_i  [GPIO_PORTS],
    output soc_map_pkg::gpio_word_t          gpio_o  [GPIO_PORTS],
    output soc_map_pkg::gpio_word_t          gpio_oe [GPIO_PORTS],
    input  logic [soc_map_pkg::DEV_IRQS-1:0] dev_irq,
    output soc_map_pkg::irq_vec_t            irq,
    output logic                             irq_ext
);
    import ahb_pkg::*;
    import soc_map_pkg::*;

    logic [SLAVES-1:0] sel;               // One-hot slave select
    logic              hready;            // Common to all slaves
    ahb_rsp_t          slv_rsp [SLAVES];

    // --------------------------------------------------
    // Fabric
    // --------------------------------------------------
    ahb_decoder u_decoder
    (
        .CLK     (CLK),
        .RES_ORG (RES_ORG),
        .bus_req (bus_req),
        .sel     (sel),
        .hready  (hready),
        .slv_rsp (slv_rsp),
        .bus_rsp (bus_rsp)
    );

    // Data RAM
    ahb_ram #(.RAM_WORDS(RAM_WORDS)) u_ram
    (
        .CLK     (CLK),
        .RES_ORG (RES_ORG),
        .bus_req (bus_req),
        .sel     (sel[SLV_RAM]),
        .hready  (hready),
        .rsp     (slv_rsp[SLV_RAM])
    );

    // GPIO ports
    gpio_port #(.GPIO_PORTS(GPIO_PORTS)) u_gpio
    (
        .CLK     (CLK),
        .RES_ORG (RES_ORG),
        .bus_req (bus_req),
        .sel     (sel[SLV_GPIO]),
        .hready  (hready),
        .rsp     (slv_rsp[SLV_GPIO]),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o),
        .gpio_oe (gpio_oe)
    );

    // Interrupt generator
    int_gen u_int_gen
    (
        .CLK     (CLK),
        .RES_ORG (RES_ORG),
        .bus_req (bus_req),
        .sel     (sel[SLV_INTGEN]),
        .hready  (hready),
        .rsp     (slv_rsp[SLV_INTGEN]),
        .dev_irq (dev_irq),
        .irq     (irq),
        .irq_ext (irq_ext)
    );

endmodule

//--- verilog/int_gen.sv
module int_gen
(
    input  logic                             CLK,
    input  logic                             RES_ORG,
    input  ahb_pkg::ahb_req_t                bus_req,
    input  logic                             sel,
    input  logic                             hready,
    output ahb_pkg::ahb_rsp_t                rsp,
    input  logic [soc_map_pkg::DEV_IRQS-1:0] dev_irq,
    output soc_map_pkg::irq_vec_t            irq,
    output logic                             irq_ext
);
    import ahb_pkg::*;
    import soc_map_pkg::*;

    irq_vec_t   irq_gen;  // Software-written bits
    irq_vec_t   rd_data;
    logic       wr_q;
    logic [7:0] ofs_q;

    // Address phase
    always_ff @(posedge CLK or posedge RES_ORG)
    begin
        if (RES_ORG)
        begin
            wr_q  <= 1'b0;
            ofs_q <= '0;
        end
        else if (hready)
        begin
            wr_q  <= sel && bus_req.hwrite
                     && (bus_req.htrans == NONSEQ || bus_req.htrans == SEQ);
            ofs_q <= bus_req.haddr[7:0];
        end
    end

    // Register writes in data phase
    always_ff @(posedge CLK or posedge RES_ORG)
    begin
        if (RES_ORG)
        begin
            irq_gen <= '0;
            irq_ext <= 1'b0;
        end
        else if (wr_q && hready)
        begin
            case (ofs_q)
                IRQ_GEN_OFS: irq_gen <= bus_req.hwdata;
                IRQ_EXT_OFS: irq_ext <= bus_req.hwdata[0];
                default:     ;  // Status is read only
            endcase
        end
    end

    // Device lines pass straight through to irq
    assign irq = irq_gen | {{(IRQ_W-DEV_IRQS){1'b0}}, dev_irq};

    always_comb
    begin
        case (ofs_q)
            IRQ_GEN_OFS:  rd_data = irq_gen;
            IRQ_EXT_OFS:  rd_data = {{(IRQ_W-1){1'b0}}, irq_ext};
            IRQ_STAT_OFS: rd_data = irq;
            default:      rd_data = '0;
        endcase
    end

    assign rsp = '{hreadyout: 1'b1, hresp: OKAY, hrdata: rd_data};

endmodule

//--- verilog/gpio_port.sv
module gpio_port
#(
    parameter int GPIO_PORTS = 2
)
(
    input  logic                    CLK,
    input  logic                    RES_ORG,
    input  ahb_pkg::ahb_req_t       bus_req,
    input  logic                    sel,
    input  logic                    hready,
    output ahb_pkg::ahb_rsp_t       rsp,
    input  soc_map_pkg::gpio_word_t gpio_i  [GPIO_PORTS],
    output soc_map_pkg::gpio_word_t gpio_o  [GPIO_PORTS],
    output soc_map_pkg::gpio_word_t gpio_oe [GPIO_PORTS]
);
    import ahb_pkg::*;
    import soc_map_pkg::*;

    gpio_word_t sync_1 [GPIO_PORTS];  // First synchronizer stage
    gpio_word_t sync_2 [GPIO_PORTS];  // Readable stage
    gpio_word_t rd_data;
    logic       wr_q;
    logic [7:0] ofs_q;
    logic [7:0] port_idx;
    logic [7:0] reg_ofs;

    assign port_idx = ofs_q / GPIO_STRIDE;
    assign reg_ofs  = ofs_q % GPIO_STRIDE;

    // Address phase
    always_ff @(posedge CLK or posedge RES_ORG)
    begin
        if (RES_ORG)
        begin
            wr_q  <= 1'b0;
            ofs_q <= '0;
        end
        else if (hready)
        begin
            wr_q  <= sel && bus_req.hwrite
                     && (bus_req.htrans == NONSEQ || bus_req.htrans == SEQ);
            ofs_q <= bus_req.haddr[7:0];
        end
    end

    // --------------------------------------------------
    // Port registers and input synchronizers
    // --------------------------------------------------
    always_ff @(posedge CLK or posedge RES_ORG)
    begin
        if (RES_ORG)
        begin
            for (int p = 0; p < GPIO_PORTS; p++)
            begin
                gpio_o[p]  <= '0;
                gpio_oe[p] <= '0;
                sync_1[p]  <= '0;
                sync_2[p]  <= '0;
            end
        end
        else
        begin
            for (int p = 0; p < GPIO_PORTS; p++)
            begin
                sync_1[p] <= gpio_i[p];
                sync_2[p] <= sync_1[p];
                // Input offset and missing ports ignore writes
                if (wr_q && hready && port_idx == p && reg_ofs == GPIO_O_OFS)
                    gpio_o[p] <= bus_req.hwdata;
                if (wr_q && hready && port_idx == p && reg_ofs == GPIO_OE_OFS)
                    gpio_oe[p] <= bus_req.hwdata;
            end
        end
    end

    // Read mux, zero for missing ports
    always_comb
    begin
        rd_data = '0;
        for (int p = 0; p < GPIO_PORTS; p++)
            if (port_idx == p)
                case (reg_ofs)
                    GPIO_O_OFS:  rd_data = gpio_o[p];
                    GPIO_OE_OFS: rd_data = gpio_oe[p];
                    GPIO_I_OFS:  rd_data = sync_2[p];
                    default:     rd_data = '0;
                endcase
    end

    assign rsp = '{hreadyout: 1'b1, hresp: OKAY, hrdata: rd_data};

endmodule

//--- verilog/ahb_ram.sv
module ahb_ram
#(
    parameter int RAM_WORDS = 256
)
(
    input  logic              CLK,
    input  logic              RES_ORG,
    input  ahb_pkg::ahb_req_t bus_req,
    input  logic              sel,
    input  logic              hready,
    output ahb_pkg::ahb_rsp_t rsp
);
    import ahb_pkg::*;

    // Smaller RAM wraps inside the 1 KB window
    localparam int WA_W = $clog2(RAM_WORDS);

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic              wr_q;    // Write pending in data phase
    hsize_t            size_q;
    logic [WA_W-1:0]   word_q;
    logic [1:0]        lane_q;  // Low address bits
    logic [3:0]        be;

    // Address phase
    always_ff @(posedge CLK or posedge RES_ORG)
    begin
        if (RES_ORG)
            wr_q <= 1'b0;
        else if (hready)
            wr_q <= sel && bus_req.hwrite
                    && (bus_req.htrans == NONSEQ || bus_req.htrans == SEQ);
    end

    always_ff @(posedge CLK)
    begin
        if (hready && sel)
        begin
            size_q <= bus_req.hsize;
            word_q <= bus_req.haddr[WA_W+1:2];
            lane_q <= bus_req.haddr[1:0];
        end
    end

    // Byte lanes from size and low address bits
    always_comb
    begin
        case (size_q)
            BYTE:    be = 4'b0001 << lane_q;
            HALF:    be = lane_q[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;
        endcase
    end

    // Data phase write
    always_ff @(posedge CLK)
    begin
        if (wr_q && hready)
            for (int b = 0; b < 4; b++)
                if (be[b])
                    mem[word_q][8*b +: 8] <= bus_req.hwdata[8*b +: 8];
    end

    // Zero wait states
    assign rsp = '{hreadyout: 1'b1, hresp: OKAY, hrdata: mem[word_q]};

endmodule

//--- verilog/ahb_decoder.sv
module ahb_decoder
(
    input  logic                           CLK,
    input  logic                           RES_ORG,
    input  ahb_pkg::ahb_req_t              bus_req,
    output logic [soc_map_pkg::SLAVES-1:0] sel,
    output logic                           hready,
    input  ahb_pkg::ahb_rsp_t              slv_rsp [soc_map_pkg::SLAVES],
    output ahb_pkg::ahb_rsp_t              bus_rsp
);
    import ahb_pkg::*;
    import soc_map_pkg::*;

    // Default slave, two-cycle ERROR
    typedef enum logic [1:0] {ERR_IDLE, ERR_FIRST, ERR_LAST} err_state_t;

    typedef struct packed
    {
        logic     act;  // Mapped transfer in data phase
        slv_idx_t slv;  // Slave that owns it
    } dphase_t;

    dphase_t    dphase;
    err_state_t err_state;
    slv_idx_t   hit_idx;
    logic       active;
    logic       addr_phase;

    // --------------------------------------------------
    // Address decode, base and mask per slave
    // --------------------------------------------------
    always_comb
    begin
        hit_idx = SLV_RAM;
        for (int i = 0; i < SLAVES; i++)
        begin
            sel[i] = (bus_req.haddr & SLV_MASK[i]) == SLV_BASE[i];
            if (sel[i])
                hit_idx = slv_idx_t'(i);  // Windows never overlap
        end
    end

    assign active     = (bus_req.htrans == NONSEQ) || (bus_req.htrans == SEQ);
    assign addr_phase = active && hready;

    // Owner of the next data phase, held while stalled
    always_ff @(posedge CLK or posedge RES_ORG)
    begin
        if (RES_ORG)
            dphase <= '0;
        else if (hready)
        begin
            dphase.act <= active && (|sel);
            dphase.slv <= hit_idx;
        end
    end

    // Unmapped transfer -> low-ERROR cycle, then high-ERROR cycle
    always_ff @(posedge CLK or posedge RES_ORG)
    begin
        if (RES_ORG)
            err_state <= ERR_IDLE;
        else if (err_state == ERR_FIRST)
            err_state <= ERR_LAST;      // Bus stalled, no new address
        else if (addr_phase && !(|sel))
            err_state <= ERR_FIRST;
        else
            err_state <= ERR_IDLE;
    end

    // --------------------------------------------------
    // Response mux
    // --------------------------------------------------
    always_comb
    begin
        case (err_state)
            ERR_FIRST: bus_rsp = '{hreadyout: 1'b0, hresp: ERROR, hrdata: '0};
            ERR_LAST:  bus_rsp = '{hreadyout: 1'b1, hresp: ERROR, hrdata: '0};
            default:
            begin
                if (dphase.act)
                    bus_rsp = slv_rsp[dphase.slv];
                else
                    bus_rsp = '{hreadyout: 1'b1, hresp: OKAY, hrdata: '0};  // Idle bus
            end
        endcase
    end

    assign hready = bus_rsp.hreadyout;  // Shared by all slaves

endmodule

//--- verilog/soc_map_pkg.sv
package soc_map_pkg;

    // --------------------------------------------------
    // Slave map
    // --------------------------------------------------
    localparam int SLAVES = 3;

    typedef logic [1:0] slv_idx_t;

    localparam slv_idx_t SLV_RAM    = 2'd0;
    localparam slv_idx_t SLV_GPIO   = 2'd1;
    localparam slv_idx_t SLV_INTGEN = 2'd2;

    // Indexed by SLV_*, hit when (haddr & mask) == base
    localparam logic [31:0] SLV_BASE [SLAVES] = '{32'h2000_0000, 32'h4000_0000, 32'h4000_1000};
    localparam logic [31:0] SLV_MASK [SLAVES] = '{32'hFFFF_FC00, 32'hFFFF_FF00, 32'hFFFF_FF00};

    // --------------------------------------------------
    // Register offsets inside a 256 byte window
    // --------------------------------------------------
    localparam logic [7:0] GPIO_O_OFS   = 8'h00;  // Output data
    localparam logic [7:0] GPIO_OE_OFS  = 8'h04;  // Output enable
    localparam logic [7:0] GPIO_I_OFS   = 8'h08;  // Synchronized input, read only
    localparam logic [7:0] GPIO_STRIDE  = 8'h10;  // One register group per port

    localparam logic [7:0] IRQ_GEN_OFS  = 8'h00;  // Software interrupt bits
    localparam logic [7:0] IRQ_EXT_OFS  = 8'h04;  // External interrupt, bit 0
    localparam logic [7:0] IRQ_STAT_OFS = 8'h08;  // Merged vector, read only

    // Interrupts
    localparam int IRQ_W    = 32;
    localparam int DEV_IRQS = 6;   // Device lines land on irq[5:0]

    typedef logic [IRQ_W-1:0] irq_vec_t;
    typedef logic [31:0]      gpio_word_t;

endpackage

//--- verilog/ahb_pkg.sv
package ahb_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Transfer type, NONSEQ and SEQ carry a transfer
    typedef enum logic [1:0] {IDLE = 2'b00, BUSY = 2'b01, NONSEQ = 2'b10, SEQ = 2'b11} htrans_t;

    // Transfer size, up to one bus word
    typedef enum logic [2:0] {BYTE = 3'b000, HALF = 3'b001, WORD = 3'b010} hsize_t;

    // Single-bit AHB-Lite response
    typedef enum logic {OKAY = 1'b0, ERROR = 1'b1} hresp_t;

    // --------------------------------------------------
    // Master to slave, 70 bits
    // --------------------------------------------------
    typedef struct packed
    {
        htrans_t             htrans;
        logic                hwrite;  // 1 = write
        hsize_t              hsize;
        logic [ADDR_W-1:0]   haddr;
        logic [DATA_W-1:0]   hwdata;  // Valid in data phase only
    } ahb_req_t;

    // Slave to master, 34 bits
    typedef struct packed
    {
        logic                hreadyout;  // Low stretches the data phase
        hresp_t              hresp;
        logic [DATA_W-1:0]   hrdata;
    } ahb_rsp_t;

endpackage
